/* design/morseTrainer_defs.svh */
// -------------------------------------------------
// the Morse table in letterGenerator is fixed at five 2-bit symbols,
// so CODE_BITS stays 10 unless the table is rewritten
// -------------------------------------------------
`ifndef MORSE_TRAINER_DEFS_SVH
`define MORSE_TRAINER_DEFS_SVH

// characters drawn per round
`define NUM_LETTERS 5

// five symbols of 2 bits, first symbol in the top bits
`define CODE_BITS 10

// letter index and LFSR share this width
`define LETTER_BITS 6

`define DASH_TICKS 10 // hold cycles at which a press becomes a dash
`define TIMER_BITS 8

`endif

/* design/morsePkg.sv */
// -------------------------------------------------
// shared types for the trainer, widths come from morseTrainer_defs.svh
// -------------------------------------------------
`include "morseTrainer_defs.svh"

package morsePkg;

	typedef logic [`CODE_BITS-1:0] morseCode_t; // 10 dot, 11 dash, 00 empty
	typedef logic [`LETTER_BITS-1:0] letterIdx_t; // 1..10 digits, 11..36 A..Z
	typedef logic [2:0] count_t;

	typedef enum logic [3:0] {
		IDLE,
		START_WAIT,
		GENERATE,
		CLEAR_ENTRY,
		ENTRY,
		VERIFY_WAIT,
		VERIFY,
		FINISH,
		FINISH_WAIT
	} phase_t;

	typedef struct packed {
		logic genEn;
		logic clearEntry;
		logic keyEnable;
		logic verify;
	} ctrl_t;

	typedef struct packed {
		logic genDone;
		logic correct;
		logic lastLetter;
		logic finished;
	} status_t;

endpackage

/* design/gameControl.sv */
// -------------------------------------------------
// proceed is active low, every transition waits for a full press or release
// -------------------------------------------------
`timescale 1ns/1ps

module gameControl
	import morsePkg::*;
(
	input logic clk,
	input logic reset,
	input logic proceed,
	input status_t status,
	output ctrl_t ctrl,
	output phase_t phase
);

	phase_t nextPhase;

	always_comb begin
		nextPhase = phase;
		case (phase)
			IDLE: begin
				if (!proceed) nextPhase = START_WAIT;
			end
			START_WAIT: begin
				if (proceed) nextPhase = GENERATE; // start on release
			end
			GENERATE: begin
				if (status.genDone) nextPhase = CLEAR_ENTRY;
			end
			CLEAR_ENTRY: begin
				nextPhase = ENTRY;
			end
			ENTRY: begin
				if (!proceed) nextPhase = VERIFY_WAIT;
			end
			VERIFY_WAIT: begin
				if (proceed) nextPhase = VERIFY;
			end
			VERIFY: begin
				// a wrong entry just retries the same letter
				if (status.correct && status.lastLetter) nextPhase = FINISH;
				else nextPhase = CLEAR_ENTRY;
			end
			FINISH: begin
				if (!proceed) nextPhase = FINISH_WAIT;
			end
			FINISH_WAIT: begin
				if (proceed) nextPhase = IDLE;
			end
			default: begin
				nextPhase = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			phase <= IDLE;
		end else begin
			phase <= nextPhase;
		end
	end

	// one strobe per phase, all low in the waiting states
	assign ctrl = '{
		genEn: phase == GENERATE,
		clearEntry: phase == CLEAR_ENTRY,
		keyEnable: phase == ENTRY,
		verify: phase == VERIFY
	};

	// generation and verification never overlap
	assert property (@(posedge clk) disable iff (!reset)
		!(ctrl.verify && ctrl.genEn));

	// the checker must have flagged the last match before we sit in FINISH
	assert property (@(posedge clk) disable iff (!reset)
		phase == FINISH |-> status.finished);

endmodule

/* design/pressTimer.sv */
// -------------------------------------------------
// saturates at all ones, so very long holds still read as a dash
// -------------------------------------------------
`timescale 1ns/1ps
`include "morseTrainer_defs.svh"

module pressTimer (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic run,
	output logic isDash
);

	localparam logic [`TIMER_BITS-1:0] DASH_LEVEL = `DASH_TICKS;

	logic [`TIMER_BITS-1:0] count;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (run && count != '1) begin
			count <= count + 1'b1;
		end
	end

	assign isDash = count >= DASH_LEVEL;

	// between clears the count only grows
	assert property (@(posedge clk) disable iff (!reset)
		!clear |=> count >= $past(count));

endmodule

/* design/morseKeyer.sv */
// -------------------------------------------------
// keyIn is active low and sampled without a synchronizer
// the code updates 2 cycles after the release edge
// -------------------------------------------------
`timescale 1ns/1ps
`include "morseTrainer_defs.svh"

module morseKeyer
	import morsePkg::*;
(
	input logic clk,
	input logic reset,
	input logic keyIn,
	input ctrl_t ctrl,
	output morseCode_t enteredCode
);

	localparam int SLOTS = `CODE_BITS / 2;

	typedef enum logic [1:0] {KEY_WAIT, KEY_DOWN, KEY_RELEASE, KEY_APPEND} keyState_t;

	keyState_t state;
	keyState_t nextState;
	logic [2:0] slotsUsed;
	logic isDash;
	logic timerClear;
	logic timerRun;
	logic [1:0] symbol;

	pressTimer i_pressTimer (
		.clk,
		.reset,
		.clear(timerClear),
		.run(timerRun),
		.isDash
	);

	always_comb begin
		nextState = state;
		case (state)
			KEY_WAIT: if (!keyIn) nextState = KEY_DOWN;
			KEY_DOWN: if (keyIn) nextState = KEY_RELEASE;
			KEY_RELEASE: nextState = KEY_APPEND;
			default: nextState = KEY_WAIT;
		endcase
		if (!ctrl.keyEnable) nextState = KEY_WAIT; // presses outside ENTRY are dropped
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= KEY_WAIT;
		end else begin
			state <= nextState;
		end
	end

	// first low sample already counts as one cycle of hold
	assign timerRun = ctrl.keyEnable && !keyIn && (state == KEY_WAIT || state == KEY_DOWN);
	assign timerClear = !ctrl.keyEnable || state == KEY_APPEND;
	assign symbol = isDash ? 2'b11 : 2'b10;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			enteredCode <= '0;
			slotsUsed <= '0;
		end else if (ctrl.clearEntry) begin
			enteredCode <= '0;
			slotsUsed <= '0;
		end else if (state == KEY_APPEND) begin
			if (slotsUsed < SLOTS) begin
				enteredCode[`CODE_BITS - 2 - 2 * slotsUsed +: 2] <= symbol;
				slotsUsed <= slotsUsed + 1'b1;
			end else begin
				enteredCode <= {enteredCode[`CODE_BITS-3:0], symbol}; // oldest symbol drops out
			end
		end
	end

endmodule

/* design/letterGenerator.sv */
// -------------------------------------------------
// LFSR reloads the seed outside GENERATE, so a seed always gives the
// same round. seed must be nonzero
// -------------------------------------------------
`timescale 1ns/1ps
`include "morseTrainer_defs.svh"

module letterGenerator
	import morsePkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`LETTER_BITS-1:0] seed,
	input ctrl_t ctrl,
	output logic wrEn,
	output letterIdx_t wrLetter,
	output morseCode_t wrCode,
	output logic genDone
);

	localparam letterIdx_t MAX_INDEX = 36;
	localparam count_t LETTERS = `NUM_LETTERS;

	logic [`LETTER_BITS-1:0] lfsr;
	count_t written;
	logic valid;

	function automatic morseCode_t morseOf(letterIdx_t idx);
		case (idx)
			6'd1: return 10'b11_11_11_11_11; // 0
			6'd2: return 10'b10_11_11_11_11;
			6'd3: return 10'b10_10_11_11_11;
			6'd4: return 10'b10_10_10_11_11;
			6'd5: return 10'b10_10_10_10_11;
			6'd6: return 10'b10_10_10_10_10;
			6'd7: return 10'b11_10_10_10_10;
			6'd8: return 10'b11_11_10_10_10;
			6'd9: return 10'b11_11_11_10_10;
			6'd10: return 10'b11_11_11_11_10; // 9
			6'd11: return 10'b10_11_00_00_00; // A
			6'd12: return 10'b11_10_10_10_00;
			6'd13: return 10'b11_10_11_10_00;
			6'd14: return 10'b11_10_10_00_00;
			6'd15: return 10'b10_00_00_00_00;
			6'd16: return 10'b10_10_11_10_00;
			6'd17: return 10'b11_11_10_00_00;
			6'd18: return 10'b10_10_10_10_00;
			6'd19: return 10'b10_10_00_00_00;
			6'd20: return 10'b10_11_11_11_00;
			6'd21: return 10'b11_10_11_00_00;
			6'd22: return 10'b10_11_10_10_00;
			6'd23: return 10'b11_11_00_00_00;
			6'd24: return 10'b11_10_00_00_00;
			6'd25: return 10'b11_11_11_00_00;
			6'd26: return 10'b10_11_11_10_00;
			6'd27: return 10'b11_11_10_11_00;
			6'd28: return 10'b10_11_10_00_00;
			6'd29: return 10'b10_10_10_00_00;
			6'd30: return 10'b11_00_00_00_00;
			6'd31: return 10'b10_10_11_00_00;
			6'd32: return 10'b10_10_10_11_00;
			6'd33: return 10'b10_11_11_00_00;
			6'd34: return 10'b11_10_10_11_00;
			6'd35: return 10'b11_10_11_11_00;
			6'd36: return 10'b11_11_10_10_00; // Z
			default: return '0;
		endcase
	endfunction

	// x^6 + x^5 + 1, shifting right
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			lfsr <= seed;
		end else if (!ctrl.genEn || lfsr == '0) begin
			lfsr <= seed;
		end else begin
			lfsr <= {lfsr[0] ^ lfsr[1], lfsr[`LETTER_BITS-1:1]};
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			written <= '0;
		end else if (!ctrl.genEn) begin
			written <= '0;
		end else if (wrEn) begin
			written <= written + 1'b1;
		end
	end

	assign valid = lfsr != '0 && lfsr <= MAX_INDEX; // 37..63 are skipped
	assign genDone = written == LETTERS;
	assign wrEn = ctrl.genEn && valid && !genDone;
	assign wrLetter = lfsr;
	assign wrCode = morseOf(lfsr);

	// a zero seed would leave the LFSR stuck
	assert property (@(posedge clk) disable iff (!reset)
		(!ctrl.genEn || lfsr == '0) |-> seed != '0);

endmodule

/* design/sequenceQueue.sv */
// -------------------------------------------------
// emptied on the rising edge of clearAll, a write in that cycle lands at the head
// -------------------------------------------------
`timescale 1ns/1ps
`include "morseTrainer_defs.svh"

module sequenceQueue #(
	parameter type T = logic [7:0],
	parameter int DEPTH = `NUM_LETTERS
) (
	input logic clk,
	input logic reset,
	input logic clearAll,
	input logic wrEn,
	input logic advance,
	input T wrData,
	output T head
);

	localparam int PTR_BITS = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] wrSlot;
	logic clearAllQ;
	logic clearRise;

	assign clearRise = clearAll && !clearAllQ;
	assign wrSlot = clearRise ? '0 : wrPtr;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wrPtr <= '0;
			clearAllQ <= 1'b0;
		end else begin
			clearAllQ <= clearAll;
			if (wrEn) wrPtr <= wrSlot + 1'b1;
			else if (clearRise) wrPtr <= '0;
			else if (advance && wrPtr != '0) wrPtr <= wrPtr - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrSlot] <= wrData;
		end else if (advance) begin
			for (int i = 0; i < DEPTH - 1; i++) mem[i] <= mem[i + 1];
		end
	end

	assign head = (wrPtr != '0) ? mem[0] : '0; // empty shows 0

	// generator must stop at DEPTH entries
	assert property (@(posedge clk) disable iff (!reset)
		wrEn && !clearRise |-> wrPtr < DEPTH);

endmodule

/* design/sequenceChecker.sv */
// -------------------------------------------------
// an empty entry never matches, so correct stays low while idle
// -------------------------------------------------
`timescale 1ns/1ps
`include "morseTrainer_defs.svh"

module sequenceChecker
	import morsePkg::*;
(
	input logic clk,
	input logic reset,
	input ctrl_t ctrl,
	input morseCode_t enteredCode,
	input morseCode_t targetCode,
	output logic advance,
	output logic correct,
	output logic lastLetter,
	output logic finished,
	output count_t lettersDone
);

	localparam count_t LAST = count_t'(`NUM_LETTERS - 1);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			correct <= 1'b0;
		end else begin
			correct <= enteredCode == targetCode && enteredCode != '0;
		end
	end

	assign advance = ctrl.verify && correct;
	assign lastLetter = lettersDone == LAST;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			lettersDone <= '0;
			finished <= 1'b0;
		end else if (ctrl.genEn) begin
			lettersDone <= '0; // new round
			finished <= 1'b0;
		end else if (advance) begin
			lettersDone <= lettersDone + 1'b1;
			if (lastLetter) finished <= 1'b1;
		end
	end

endmodule

/* design/morseTrainer.sv */
// -------------------------------------------------
// proceed and keyIn are active low buttons, seed must be nonzero
// -------------------------------------------------
`timescale 1ns/1ps
`include "morseTrainer_defs.svh"

module morseTrainer
	import morsePkg::*;
(
	input logic clk,
	input logic reset,
	input logic proceed,
	input logic keyIn,
	input logic [`LETTER_BITS-1:0] seed,
	output morseCode_t targetCode,
	output letterIdx_t targetLetter,
	output morseCode_t enteredCode,
	output count_t lettersDone,
	output logic correct,
	output logic finished,
	output phase_t phase
);

	ctrl_t ctrl;
	status_t status;
	logic wrEn;
	logic genDone;
	logic advance;
	logic lastLetter;
	letterIdx_t wrLetter;
	morseCode_t wrCode;

	assign status = '{genDone: genDone, correct: correct, lastLetter: lastLetter,
		finished: finished};

	gameControl i_gameControl (.clk, .reset, .proceed, .status, .ctrl, .phase);

	morseKeyer i_morseKeyer (.clk, .reset, .keyIn, .ctrl, .enteredCode);

	letterGenerator i_letterGenerator (
		.clk, .reset, .seed, .ctrl, .wrEn, .wrLetter, .wrCode, .genDone
	);

	// both queues clear as generation starts and advance together
	sequenceQueue #(.T(letterIdx_t)) i_letterQueue (
		.clk, .reset, .clearAll(ctrl.genEn), .wrEn, .advance,
		.wrData(wrLetter), .head(targetLetter)
	);

	sequenceQueue #(.T(morseCode_t)) i_codeQueue (
		.clk, .reset, .clearAll(ctrl.genEn), .wrEn, .advance,
		.wrData(wrCode), .head(targetCode)
	);

	sequenceChecker i_sequenceChecker (
		.clk, .reset, .ctrl, .enteredCode, .targetCode,
		.advance, .correct, .lastLetter, .finished, .lettersDone
	);

endmodule

/* verif/tbMorseTrainer.sv */
// -------------------------------------------------
// run from the project root, the trace path is relative to it
// -------------------------------------------------
`timescale 1ns/1ps
`include "morseTrainer_defs.svh"

module tbMorseTrainer
	import morsePkg::*;
();

	localparam int TRACE_WORDS = 256;
	localparam int GAP_CYCLES = 1; // idle cycles between two presses

	logic clk = 1'b0;
	logic reset;
	logic proceed;
	logic keyIn;
	logic [`LETTER_BITS-1:0] seed;
	morseCode_t targetCode;
	letterIdx_t targetLetter;
	morseCode_t enteredCode;
	count_t lettersDone;
	logic correct;
	logic finished;
	phase_t phase;

	logic [15:0] trace [TRACE_WORDS];
	letterIdx_t expLetter [`NUM_LETTERS];
	morseCode_t expTarget [`NUM_LETTERS];
	int tracePos;
	int headPos;
	int cycles;
	int cycleLimit;
	int errorCount = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorsAtStart;
	string testName;

	morseTrainer i_morseTrainer (
		.clk(clk),
		.reset(reset),
		.proceed(proceed),
		.keyIn(keyIn),
		.seed(seed),
		.targetCode(targetCode),
		.targetLetter(targetLetter),
		.enteredCode(enteredCode),
		.lettersDone(lettersDone),
		.correct(correct),
		.finished(finished),
		.phase(phase)
	);

	always #4 clk = ~clk;

	task automatic compareValue(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checkCount++;
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h (%s)", name, actual, expected,
				testName);
			errorCount++;
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		errorsAtStart = errorCount;
		testsRun++;
	endtask

	task automatic endTest();
		if (errorCount == errorsAtStart) begin
			$display("test %0d %s: ok", testsRun, testName);
		end else begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testsRun, testName, errorCount - errorsAtStart);
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	// full press and release, the phase moves on with the release
	task automatic pressProceed();
		proceed = 1'b0;
		nextCycle();
		proceed = 1'b1;
		nextCycle();
	endtask

	task automatic waitEntryOrFinish();
		while (phase != ENTRY && phase != FINISH) begin
			nextCycle();
		end
	endtask

	// code holds the last five symbols in keying order with the oldest on top
	function automatic morseCode_t codeOfHolds(input int holds [$]);
		morseCode_t code;
		morseCode_t sym;
		int first;
		int slot;
		code = '0;
		first = holds.size() - `CODE_BITS / 2;
		if (first < 0) first = 0;
		for (int i = first; i < holds.size(); i++) begin
			sym = (holds[i] >= `DASH_TICKS) ? 2'b11 : 2'b10;
			slot = i - first;
			code = code | (sym << (`CODE_BITS - 2 - 2 * slot));
		end
		return code;
	endfunction

	function automatic int traceCycles();
		int pos;
		int total;
		pos = 1 + 2 * `NUM_LETTERS;
		total = 200; // reset, generation, finish and margin
		while (pos < TRACE_WORDS && trace[pos] != 16'h0 && !$isunknown(trace[pos])) begin
			total += 20;
			for (int i = 1; i <= int'(trace[pos]); i++) begin
				total += int'(trace[pos + i]) + 4 + GAP_CYCLES;
			end
			pos += int'(trace[pos]) + 3;
		end
		return total;
	endfunction

	task automatic keySymbol(input int hold, input morseCode_t previous,
		input morseCode_t expected);
		keyIn = 1'b0;
		repeat (hold) @(posedge clk);
		#1;
		keyIn = 1'b1;
		nextCycle(); // first edge that sees the key up
		nextCycle();
		compareValue("enteredCode", enteredCode, previous);
		nextCycle();
		compareValue("enteredCode", enteredCode, expected);
		repeat (GAP_CYCLES) nextCycle();
	endtask

	task automatic runStep(input int stepNo);
		int count;
		int hold;
		int holds [$];
		morseCode_t model;
		morseCode_t nextCode;
		morseCode_t traceCode;
		logic match;
		count = trace[tracePos];
		model = '0;
		beginTest($sformatf("step %0d with %0d symbols", stepNo, count));
		compareValue("phase", phase, ENTRY);
		for (int i = 0; i < count; i++) begin
			hold = trace[tracePos + 1 + i];
			holds.push_back(hold);
			nextCode = codeOfHolds(holds);
			keySymbol(hold, model, nextCode);
			model = nextCode;
		end
		traceCode = trace[tracePos + count + 1][`CODE_BITS-1:0];
		match = trace[tracePos + count + 2][0];
		tracePos += count + 3;
		compareValue("enteredCode", enteredCode, traceCode);
		pressProceed();
		compareValue("phase", phase, VERIFY);
		compareValue("correct", correct, match);
		waitEntryOrFinish();
		if (!match) begin
			compareValue("phase", phase, ENTRY);
			compareValue("lettersDone", lettersDone, headPos);
			compareValue("targetCode", targetCode, expTarget[headPos]);
			compareValue("enteredCode", enteredCode, '0);
		end else if (headPos == `NUM_LETTERS - 1) begin
			compareValue("phase", phase, FINISH);
			compareValue("finished", finished, 1'b1);
			compareValue("lettersDone", lettersDone, `NUM_LETTERS);
		end else begin
			headPos++;
			compareValue("phase", phase, ENTRY);
			compareValue("lettersDone", lettersDone, headPos);
			compareValue("targetLetter", targetLetter, expLetter[headPos]);
			compareValue("targetCode", targetCode, expTarget[headPos]);
			compareValue("enteredCode", enteredCode, '0);
		end
		endTest();
	endtask

	initial begin
		int stepNo;
		reset = 1'b0;
		proceed = 1'b1;
		keyIn = 1'b1;
		$readmemh("verif/morseTrace.txt", trace);
		seed = trace[0][`LETTER_BITS-1:0];
		for (int i = 0; i < `NUM_LETTERS; i++) begin
			expLetter[i] = trace[1 + 2 * i][`LETTER_BITS-1:0];
			expTarget[i] = trace[2 + 2 * i][`CODE_BITS-1:0];
		end
		cycleLimit = traceCycles();
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b1;

		beginTest("reset values");
		compareValue("phase", phase, IDLE);
		compareValue("targetCode", targetCode, '0);
		compareValue("enteredCode", enteredCode, '0);
		compareValue("lettersDone", lettersDone, '0);
		compareValue("correct", correct, 1'b0);
		compareValue("finished", finished, 1'b0);
		endTest();

		beginTest("start and generate");
		pressProceed();
		compareValue("phase", phase, GENERATE);
		waitEntryOrFinish();
		compareValue("phase", phase, ENTRY);
		compareValue("targetLetter", targetLetter, expLetter[0]);
		compareValue("targetCode", targetCode, expTarget[0]);
		compareValue("lettersDone", lettersDone, '0);
		endTest();

		tracePos = 1 + 2 * `NUM_LETTERS;
		headPos = 0;
		stepNo = 0;
		while (tracePos < TRACE_WORDS && trace[tracePos] != 16'h0
			&& !$isunknown(trace[tracePos])) begin
			stepNo++;
			runStep(stepNo);
		end
		if (tracePos >= TRACE_WORDS || $isunknown(trace[tracePos])) begin
			$display("trace ends without the 00 marker after step %0d", stepNo);
			errorCount++;
		end

		beginTest("return to idle");
		compareValue("finished", finished, 1'b1);
		pressProceed();
		compareValue("phase", phase, IDLE);
		endTest();

		$display("tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
			checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// limit comes from the hold and gap cycles in the trace
	initial begin
		cycles = 0;
		@(posedge clk);
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
		$display("Verification failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+design
design/morsePkg.sv
design/gameControl.sv
design/pressTimer.sv
design/morseKeyer.sv
design/letterGenerator.sv
design/sequenceQueue.sv
design/sequenceChecker.sv
design/morseTrainer.sv
verif/tbMorseTrainer.sv

/* Makefile */
# Verilator build and run of the Morse trainer testbench
VERILATOR ?= verilator
TOP ?= tbMorseTrainer
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= Verification passed
SOURCES := $(wildcard design/*.sv design/*.svh verif/*.sv) verif/morseTrace.txt

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/morseTrace.txt */
// seed, then one line per letter: letter index and Morse code (10 dot, 11 dash, 00 empty)
// steps: symbol count, hold cycles per symbol, expected enteredCode, 1 if it matches; 00 ends
19          // seed 25
19 3f0      // O  ---
16 2e8      // L  .-..
15 3b0      // K  -.-
1f 2b0      // U  ..-
0f 200      // E  .

// wrong entries for O
// hold 09 is the longest dot and 0a the shortest dash
// the sixth symbol pushes the first one out
06 09 0a 02 0c 05 10 3bb 0
02 0c 0c 3c0 0

// the five letters in order
03 0c 0e 0b 3f0 1
04 03 0c 02 04 2e8 1
03 0d 03 0f 3b0 1
03 02 04 0a 2b0 1
01 01 200 1
00
